//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_game -f tb.f -o sim_game
	./obj_dir/sim_game | tee sim.log
	! grep -q "Done: errors found" sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- source/beeper.sv
`timescale 1ns/1ps

module beeper #(
    parameter int unsigned BEEP_CYCLES = 25_000_000
) (
    input  logic                   clk,
    input  logic                   sw,
    input  game_pkg::game_status_t status,
    output logic                   beep
);

    localparam int unsigned BEEP_W = $clog2(BEEP_CYCLES + 1);

    logic [BEEP_W-1:0] remaining;

    // a new miss restarts the full beep
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            remaining <= '0;
        end
        else if (status.miss)
        begin
            remaining <= BEEP_W'(BEEP_CYCLES);
        end
        else if (remaining != '0)
        begin
            remaining <= remaining - 1'b1;
        end
    end

    assign beep = (remaining != '0);

endmodule

//--- source/countdown_matrix.sv
`timescale 1ns/1ps

module countdown_matrix #(
    parameter int unsigned TICKS_PER_STEP = 50_000_000
) (
    input  logic                       clk,
    input  logic                       sw,
    input  game_pkg::game_status_t     status,
    output display_pkg::matrix_frame_t frame,
    output logic                       count_over
);

    localparam int unsigned TICK_W = (TICKS_PER_STEP > 1) ? $clog2(TICKS_PER_STEP) : 1;

    logic [TICK_W-1:0] ticks;
    logic [2:0]        steps;
    logic [2:0]        row_sel;
    logic [2:0]        remaining;
    logic              exhausted;

    // steps and ticks together hold the cycles still to run, minus one
    assign exhausted  = (steps == 3'd0) && (ticks == '0);
    assign count_over = status.counting && !status.count_start && exhausted;

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            ticks <= '0;
            steps <= 3'd0;
        end
        else if (status.count_start)
        begin
            // level + 3 steps, the entry cycle counts as the first tick
            steps <= 3'(status.level) + 3'd2;
            ticks <= TICK_W'(TICKS_PER_STEP - 1);
        end
        else if (status.counting && !exhausted)
        begin
            if (ticks == '0)
            begin
                steps <= steps - 3'd1;
                ticks <= TICK_W'(TICKS_PER_STEP - 1);
            end
            else
            begin
                ticks <= ticks - 1'b1;
            end
        end
    end

    // row scan runs freely
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
            row_sel <= 3'd0;
        else
            row_sel <= row_sel + 3'd1;
    end

    // bar length follows the steps left
    assign remaining = status.count_start ? 3'(status.level) + 3'd3 : steps + 3'd1;

    always_comb
    begin
        frame = '0;
        if (status.victory)
        begin
            frame.row  = 8'b1 << row_sel;
            frame.colg = 8'hff;
        end
        else if (status.counting && !count_over)
        begin
            frame.row  = 8'b1 << row_sel;
            frame.colr = ~(8'hff << remaining);
        end
    end

endmodule

//--- source/display_pkg.sv
package display_pkg;

    // one scan slice of the 8x8 red/green matrix
    typedef struct packed {
        logic [7:0] row;
        logic [7:0] colr;
        logic [7:0] colg;
    } matrix_frame_t;

    // segment order {dp, g, f, e, d, c, b, a}, lit when high
    localparam logic [7:0] seg_blank = 8'h00;

    localparam logic [9:0][7:0] seg_digit = {
        8'h6f,  // 9
        8'h7f,  // 8
        8'h07,  // 7
        8'h7d,  // 6
        8'h6d,  // 5
        8'h66,  // 4
        8'h4f,  // 3
        8'h5b,  // 2
        8'h06,  // 1
        8'h3f   // 0
    };

    // H shown on a hit and E on a miss
    localparam logic [7:0] seg_hit  = 8'h76;
    localparam logic [7:0] seg_miss = 8'h79;

endpackage

//--- source/game_control.sv
`timescale 1ns/1ps

module game_control (
    input  logic                   clk,
    input  logic                   sw,
    input  logic                   start,
    input  logic                   restart,
    input  logic [6:0]             guess,
    input  logic [6:0]             target,
    input  logic                   count_over,
    output logic                   draw,
    output game_pkg::game_status_t status,
    output logic [15:0]            led
);

    game_pkg::game_state_t state;
    game_pkg::game_state_t next_state;
    game_pkg::level_t      level;
    game_pkg::level_t      next_level;
    game_pkg::result_t     result;
    logic [6:0]            mask;
    logic                  hit;
    logic                  count_start;
    logic                  miss;

    // low bits compared at the current level
    assign mask = 7'h7f >> (3'd7 - game_pkg::level_width(level));
    assign hit  = ((guess ^ target) & mask) == 7'd0;

    always_comb
    begin
        next_state = state;
        next_level = level;
        if (restart)
        begin
            next_state = game_pkg::st_play;
            next_level = 2'd1;
        end
        else
        begin
            case (state)
                game_pkg::st_play:
                begin
                    if (count_over && start)
                        next_state = game_pkg::st_judge;
                end
                game_pkg::st_judge:
                begin
                    if (!hit)
                        next_state = game_pkg::st_play;
                    else if (level == 2'd3)
                        next_state = game_pkg::st_victory;
                    else
                    begin
                        next_state = game_pkg::st_play;
                        next_level = level + 2'd1;
                    end
                end
                default:
                    ;
            endcase
        end
    end

    // every entry to play latches a fresh target
    assign draw = (next_state == game_pkg::st_play) &&
                  ((state != game_pkg::st_play) || restart);

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            state       <= game_pkg::st_idle;
            level       <= 2'd1;
            result      <= game_pkg::res_none;
            count_start <= 1'b0;
            miss        <= 1'b0;
        end
        else
        begin
            state       <= next_state;
            level       <= next_level;
            count_start <= draw;
            miss        <= (state == game_pkg::st_judge) && !hit && !restart;
            if (restart)
                result <= game_pkg::res_none;
            else if (state == game_pkg::st_judge)
                result <= hit ? game_pkg::res_hit : game_pkg::res_miss;
        end
    end

    always_comb
    begin
        status.level       = level;
        status.result      = result;
        status.counting    = (state == game_pkg::st_play);
        status.count_start = count_start;
        status.miss        = miss;
        status.victory     = (state == game_pkg::st_victory);
    end

    // target visible only until the countdown runs out
    always_comb
    begin
        case (state)
            game_pkg::st_play:
                led = count_over ? 16'd0 : {9'd0, target & mask};
            game_pkg::st_victory:
                led = 16'hffff;
            default:
                led = 16'd0;
        endcase
    end

endmodule

//--- source/game_pkg.sv
package game_pkg;

    // controller states
    typedef enum logic [2:0] {
        st_idle    = 3'd0,
        st_play    = 3'd1,
        st_judge   = 3'd2,
        st_victory = 3'd3
    } game_state_t;

    // level number, 1 to 3
    typedef logic [1:0] level_t;

    // outcome of the last judge
    typedef enum logic [1:0] {
        res_none = 2'd0,
        res_hit  = 2'd1,
        res_miss = 2'd2
    } result_t;

    // status bundle for the output drivers
    typedef struct packed {
        level_t  level;
        result_t result;
        logic    counting;
        logic    count_start;
        logic    miss;
        logic    victory;
    } game_status_t;

    // compared target bits per level
    function automatic logic [2:0] level_width(level_t level);
        case (level)
            2'd2:    return 3'd6;
            2'd3:    return 3'd7;
            default: return 3'd5;
        endcase
    endfunction

endpackage

//--- source/game_top.sv
`timescale 1ns/1ps

module game_top #(
    parameter int unsigned TICKS_PER_STEP = 50_000_000,
    parameter int unsigned BEEP_CYCLES    = 25_000_000,
    parameter int unsigned SCAN_CYCLES    = 50_000
) (
    input  logic        clk,
    input  logic        sw,
    input  logic        start,
    input  logic        restart,
    input  logic [6:0]  guess,
    output logic [15:0] led,
    output logic [7:0]  seg,
    output logic [7:0]  dig,
    output logic [7:0]  row,
    output logic [7:0]  colg,
    output logic [7:0]  colr,
    output logic        beep
);

    logic [6:0]                 target;
    logic                       draw;
    logic                       count_over;
    game_pkg::game_status_t     status;
    display_pkg::matrix_frame_t frame;

    lfsr_random u_random (
        .clk    (clk),
        .sw     (sw),
        .draw   (draw),
        .target (target)
    );

    game_control u_control (
        .clk        (clk),
        .sw         (sw),
        .start      (start),
        .restart    (restart),
        .guess      (guess),
        .target     (target),
        .count_over (count_over),
        .draw       (draw),
        .status     (status),
        .led        (led)
    );

    countdown_matrix #(
        .TICKS_PER_STEP (TICKS_PER_STEP)
    ) u_matrix (
        .clk        (clk),
        .sw         (sw),
        .status     (status),
        .frame      (frame),
        .count_over (count_over)
    );

    seg_display #(
        .SCAN_CYCLES (SCAN_CYCLES)
    ) u_display (
        .clk    (clk),
        .sw     (sw),
        .status (status),
        .seg    (seg),
        .dig    (dig)
    );

    beeper #(
        .BEEP_CYCLES (BEEP_CYCLES)
    ) u_beeper (
        .clk    (clk),
        .sw     (sw),
        .status (status),
        .beep   (beep)
    );

    // matrix pins
    assign row  = frame.row;
    assign colr = frame.colr;
    assign colg = frame.colg;

endmodule

//--- source/lfsr_random.sv
`timescale 1ns/1ps

module lfsr_random (
    input  logic       clk,
    input  logic       sw,
    input  logic       draw,
    output logic [6:0] target
);

    // x^7 + x^6 + 1, period 127
    logic [6:0] lfsr;
    logic       feedback;

    assign feedback = lfsr[6] ^ lfsr[5];

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
            lfsr <= 7'h5a;
        else
            lfsr <= {lfsr[5:0], feedback};
    end

    // held until the next draw
    always_ff @(posedge clk)
    begin
        if (draw)
            target <= lfsr;
    end

endmodule

//--- source/seg_display.sv
`timescale 1ns/1ps

module seg_display #(
    parameter int unsigned SCAN_CYCLES = 50_000
) (
    input  logic                   clk,
    input  logic                   sw,
    input  game_pkg::game_status_t status,
    output logic [7:0]             seg,
    output logic [7:0]             dig
);

    localparam int unsigned SCAN_W = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;

    logic [SCAN_W-1:0] scan_cnt;
    logic [2:0]        digit;
    logic              active;

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            scan_cnt <= '0;
            digit    <= 3'd0;
            active   <= 1'b0;
        end
        else
        begin
            // idle is left only through the first countdown
            if (status.count_start)
                active <= 1'b1;
            if (scan_cnt == SCAN_W'(SCAN_CYCLES - 1))
            begin
                scan_cnt <= '0;
                digit    <= digit + 3'd1;
            end
            else
            begin
                scan_cnt <= scan_cnt + 1'b1;
            end
        end
    end

    // digit 0 level, digit 7 result, active-low select
    always_comb
    begin
        seg = display_pkg::seg_blank;
        dig = 8'hff;
        if (active)
        begin
            dig = ~(8'b1 << digit);
            case (digit)
                3'd0:
                    seg = display_pkg::seg_digit[status.level];
                3'd7:
                begin
                    case (status.result)
                        game_pkg::res_hit:  seg = display_pkg::seg_hit;
                        game_pkg::res_miss: seg = display_pkg::seg_miss;
                        default:            seg = display_pkg::seg_blank;
                    endcase
                end
                default:
                    ;
            endcase
        end
    end

endmodule

//--- tb.f
source/game_pkg.sv
source/display_pkg.sv
source/lfsr_random.sv
source/countdown_matrix.sv
source/game_control.sv
source/seg_display.sv
source/beeper.sv
source/game_top.sv
tb/game_properties.sv
tb/tb_game.sv

//--- tb/game_properties.sv
`timescale 1ns/1ps

module game_properties (
    input logic                   clk,
    input logic                   sw,
    input logic [15:0]            led,
    input logic [7:0]             dig,
    input logic                   beep,
    input game_pkg::game_status_t status
);

    // number of failed assertions so far
    int assert_failures = 0;

    // active-low select, at most one digit on
    a_one_digit: assert property (
        @(posedge clk) disable iff (sw) $countones(~dig) <= 1
    ) else
    begin
        assert_failures++;
        $error("more than one digit selected, dig %b", dig);
    end

    // beep follows a miss pulse by one cycle
    a_beep_after_miss: assert property (
        @(posedge clk) disable iff (sw) $rose(beep) |-> $past(status.miss)
    ) else
    begin
        assert_failures++;
        $error("beep rose without a preceding miss");
    end

    // idle right after reset release
    a_led_off_after_reset: assert property (
        @(posedge clk) $fell(sw) |-> led == 16'd0
    ) else
    begin
        assert_failures++;
        $error("led not zero after reset, led %h", led);
    end

endmodule

//--- tb/tb_game.sv
`timescale 1ns/1ps

module tb_game;

    localparam int TICKS    = 4;
    localparam int BEEP_LEN = 10;
    localparam int LIMIT    = 200;

    logic        clk;
    logic        sw;
    logic        start;
    logic        restart;
    logic [6:0]  guess;
    logic [15:0] led;
    logic [7:0]  seg;
    logic [7:0]  dig;
    logic [7:0]  row;
    logic [7:0]  colg;
    logic [7:0]  colr;
    logic        beep;
    int          value_errors;
    int          other_errors;

    game_top #(
        .TICKS_PER_STEP (4),
        .BEEP_CYCLES    (10),
        .SCAN_CYCLES    (2)
    ) UUT (
        .clk     (clk),
        .sw      (sw),
        .start   (start),
        .restart (restart),
        .guess   (guess),
        .led     (led),
        .seg     (seg),
        .dig     (dig),
        .row     (row),
        .colg    (colg),
        .colr    (colr),
        .beep    (beep)
    );

    bind game_top game_properties u_props (
        .clk    (clk),
        .sw     (sw),
        .led    (led),
        .dig    (dig),
        .beep   (beep),
        .status (status)
    );

    always #2 clk = ~clk;

    // low 5, 6 or 7 bits by level
    function automatic logic [6:0] width_mask(game_pkg::level_t level);
        return 7'h7f >> (2'd3 - level);
    endfunction

    function automatic game_pkg::level_t decode_level(logic [7:0] glyph);
        case (glyph)
            8'h06:   return 2'd1;
            8'h5b:   return 2'd2;
            8'h4f:   return 2'd3;
            default: return 2'd0;
        endcase
    endfunction

    // H for a hit, E for a miss, dark for none
    function automatic game_pkg::result_t decode_result(logic [7:0] glyph);
        case (glyph)
            8'h76:   return game_pkg::res_hit;
            8'h79:   return game_pkg::res_miss;
            8'h00:   return game_pkg::res_none;
            default: return game_pkg::result_t'(2'd3);
        endcase
    endfunction

    function automatic display_pkg::matrix_frame_t read_frame();
        display_pkg::matrix_frame_t frame;
        frame.row  = row;
        frame.colr = colr;
        frame.colg = colg;
        return frame;
    endfunction

    function automatic logic [6:0] pick_wrong_guess(logic [6:0] shown, game_pkg::level_t level);
        logic [6:0] value;
        value = 7'($urandom);
        // force a difference inside the compared bits
        if (((value ^ shown) & width_mask(level)) == 7'd0)
            value = value ^ 7'h01;
        return value;
    endfunction

    task automatic check_led(logic [15:0] got, logic [15:0] exp, string what);
        if (got !== exp)
        begin
            value_errors++;
            $display("ERR t=%0t %s: led %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_state_level(game_pkg::level_t got, game_pkg::level_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("ERR t=%0t level digit shows %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_result(game_pkg::result_t got, game_pkg::result_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("ERR t=%0t result digit code %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_frame(display_pkg::matrix_frame_t got,
                               display_pkg::matrix_frame_t exp, string what);
        if (got !== exp)
        begin
            value_errors++;
            $display("ERR t=%0t %s: frame %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(int got, int exp, string what);
        if (got != exp)
        begin
            value_errors++;
            $display("ERR t=%0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic pulse_restart();
        restart = 1'b1;
        next_cycle();
        restart = 1'b0;
    endtask

    // called in the entry cycle of play, returns at count_over
    task automatic run_countdown(game_pkg::level_t level, game_pkg::result_t exp_result,
                                 bit exp_beep, output logic [6:0] shown);
        int k;
        int beep_len;
        int beep_rise;
        bit saw_level;
        bit saw_result;
        k = 0;
        beep_len = 0;
        beep_rise = -1;
        saw_level = 1'b0;
        saw_result = 1'b0;
        shown = led[6:0];
        check_led(led & ~{9'd0, width_mask(level)}, 16'd0, "target wider than level");
        while (row != 8'd0 && k < LIMIT)
        begin
            check_led(led, {9'd0, shown}, "target held on led");
            if (dig == 8'hfe)
            begin
                check_state_level(decode_level(seg), level);
                saw_level = 1'b1;
            end
            if (dig == 8'h7f)
            begin
                check_result(decode_result(seg), exp_result);
                saw_result = 1'b1;
            end
            if (beep)
            begin
                beep_len++;
                if (beep_rise < 0)
                    beep_rise = k;
            end
            next_cycle();
            k++;
        end
        if (row != 8'd0)
        begin
            other_errors++;
            $display("timeout: countdown at level %0d never ran out", level);
        end
        if (!saw_level || !saw_result)
        begin
            other_errors++;
            $display("level or result digit was never scanned during the countdown");
        end
        check_count(k, (int'(level) + 3) * TICKS, "countdown cycles");
        check_led(led, 16'd0, "led after countdown");
        check_frame(read_frame(), '0, "frame after countdown");
        check_count(beep_len, exp_beep ? BEEP_LEN : 0, "beep cycles");
        if (exp_beep)
            check_count(beep_rise, 1, "beep rise cycle");
    endtask

    task automatic submit_guess(logic [6:0] value);
        guess = value;
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        // the single judge cycle is dark
        check_led(led, 16'd0, "led in judge");
        check_frame(read_frame(), '0, "frame in judge");
        next_cycle();
    endtask

    task automatic check_victory();
        display_pkg::matrix_frame_t expected;
        logic [7:0] prev;
        check_led(led, 16'hffff, "victory led");
        check_count($countones(row), 1, "victory rows lit");
        prev = row;
        repeat (16)
        begin
            next_cycle();
            expected.row  = {prev[6:0], prev[7]};
            expected.colr = 8'h00;
            expected.colg = 8'hff;
            check_frame(read_frame(), expected, "victory frame");
            check_led(led, 16'hffff, "victory led");
            if (dig == 8'h7f)
                check_result(decode_result(seg), game_pkg::res_hit);
            prev = row;
        end
    endtask

    task automatic test_reset();
        check_led(led, 16'd0, "led after reset");
        check_count(int'(beep), 0, "beep after reset");
        check_frame(read_frame(), '0, "frame after reset");
        check_count(int'(dig), 255, "dig after reset");
    endtask

    task automatic test_countdown();
        logic [6:0] shown;
        pulse_restart();
        check_count(int'(row != 8'd0), 1, "row lit at level entry");
        run_countdown(2'd1, game_pkg::res_none, 1'b0, shown);
    endtask

    // upper guess bits set to show that only the level width counts
    task automatic test_hits();
        logic [6:0] shown;
        pulse_restart();
        run_countdown(2'd1, game_pkg::res_none, 1'b0, shown);
        submit_guess(shown | ~width_mask(2'd1));
        run_countdown(2'd2, game_pkg::res_hit, 1'b0, shown);
        submit_guess(shown | ~width_mask(2'd2));
        run_countdown(2'd3, game_pkg::res_hit, 1'b0, shown);
        submit_guess(shown);
        check_victory();
    endtask

    task automatic test_wrong_guess();
        logic [6:0] shown;
        pulse_restart();
        run_countdown(2'd1, game_pkg::res_none, 1'b0, shown);
        submit_guess(pick_wrong_guess(shown, 2'd1));
        run_countdown(2'd1, game_pkg::res_miss, 1'b1, shown);
        submit_guess(shown);
        run_countdown(2'd2, game_pkg::res_hit, 1'b0, shown);
        submit_guess(pick_wrong_guess(shown, 2'd2));
        run_countdown(2'd2, game_pkg::res_miss, 1'b1, shown);
    endtask

    task automatic test_restart();
        logic [6:0] shown;
        pulse_restart();
        run_countdown(2'd1, game_pkg::res_none, 1'b0, shown);
        submit_guess(shown);
        check_led(led & ~16'h003f, 16'd0, "level 2 target width");
        repeat (5) next_cycle();
        pulse_restart();
        run_countdown(2'd1, game_pkg::res_none, 1'b0, shown);
    endtask

    initial
    begin
        void'($urandom(32'hedbd2f39));
        clk = 1'b0;
        sw = 1'b1;
        start = 1'b0;
        restart = 1'b0;
        guess = 7'd0;
        value_errors = 0;
        other_errors = 0;
        repeat (16) @(posedge clk);
        #1;
        sw = 1'b0;
        test_reset();
        test_countdown();
        test_hits();
        test_wrong_guess();
        test_restart();
        $display("errors: %0d wrong values, %0d other failures, %0d assertion failures",
                 value_errors, other_errors, UUT.u_props.assert_failures);
        if (value_errors == 0 && other_errors == 0 && UUT.u_props.assert_failures == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule
